// ==== wiscCore.f ====
rtl/wiscPkg.sv
rtl/regFile.sv
rtl/controlUnit.sv
rtl/alu.sv
rtl/decode.sv
rtl/wbSlave.sv
rtl/wiscCore.sv
sim/wiscCore_assert.sv
sim/wiscCoreTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= wiscCoreTb
FILELIST  ?= wiscCore.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= Regression passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== sim/wiscCoreTb.sv ====
`default_nettype none

module wiscCoreTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ackTimeout = 20;

    logic        clk;
    logic        rstN;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr;
    logic [15:0] datW;
    logic [15:0] datR;
    logic        ack;

    logic [15:0] shadow [8];
    logic [31:0] lcgState = 32'hbc81_d93c;
    int          errorCount = 0;
    int          checkCount = 0;
    int          testCount = 0;

    // four slots of opAluR give the R-format ops a fair share
    logic [4:0] opPool [16] = '{
        wiscPkg::opAluR, wiscPkg::opAluR, wiscPkg::opAluR, wiscPkg::opAluR,
        wiscPkg::opAddi, wiscPkg::opSubi, wiscPkg::opXori, wiscPkg::opAndni,
        wiscPkg::opRoli, wiscPkg::opSlli, wiscPkg::opRori, wiscPkg::opSrli,
        wiscPkg::opAddi, wiscPkg::opSubi, wiscPkg::opXori, wiscPkg::opSrli
    };

    wiscCore DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // new value of the destination register, taken from the shadow copy
    function automatic logic [15:0] expectedValue(input wiscPkg::wiscInstr_u ins);
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] se5;
        logic [15:0] ze5;
        logic [3:0]  n;
        a   = shadow[ins.rFmt.rs];
        b   = shadow[ins.rFmt.rt];
        se5 = {{11{ins.i1Fmt.imm5[4]}}, ins.i1Fmt.imm5};
        ze5 = {11'd0, ins.i1Fmt.imm5};
        n   = ins.i1Fmt.imm5[3:0];
        case (ins.rFmt.opcode)
            wiscPkg::opAddi:  return a + se5;
            wiscPkg::opSubi:  return se5 - a; // immediate minus rs
            wiscPkg::opXori:  return a ^ ze5;
            wiscPkg::opAndni: return a & ~ze5;
            wiscPkg::opRoli:  return (a << n) | (a >> (5'd16 - {1'b0, n}));
            wiscPkg::opSlli:  return a << n;
            wiscPkg::opRori:  return (a >> n) | (a << (5'd16 - {1'b0, n}));
            wiscPkg::opSrli:  return a >> n;
            wiscPkg::opLbi:   return {{8{ins.i2Fmt.imm8[7]}}, ins.i2Fmt.imm8};
            wiscPkg::opSlbi:  return {a[7:0], ins.i2Fmt.imm8};
            wiscPkg::opSeq:   return {15'd0, a == b};
            wiscPkg::opSlt:   return {15'd0, $signed(a) < $signed(b)};
            wiscPkg::opSle:   return {15'd0, $signed(a) <= $signed(b)};
            default: begin
                case (ins.rFmt.func)
                    wiscPkg::funcAdd: return a + b;
                    wiscPkg::funcSub: return b - a;
                    wiscPkg::funcXor: return a ^ b;
                    default:          return a & ~b;
                endcase
            end
        endcase
    endfunction

    function automatic logic [2:0] destIndex(input wiscPkg::wiscInstr_u ins);
        if (ins.rFmt.opcode inside {wiscPkg::opAluR, wiscPkg::opSeq,
                                    wiscPkg::opSlt, wiscPkg::opSle}) begin
            return ins.rFmt.rd;
        end else if (ins.rFmt.opcode inside {wiscPkg::opLbi, wiscPkg::opSlbi}) begin
            return ins.i2Fmt.rs;
        end else begin
            return ins.i1Fmt.rd;
        end
    endfunction

    task automatic checkValue(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("MISMATCH at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    // ack is sampled at the edge, so it is the value held over the last cycle
    task automatic waitAck();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!ack && cycles < ackTimeout);
        if (!ack) begin
            $display("timeout: the DUT gave no ack within %0d cycles at %0t", ackTimeout, $time);
            $display("Regression failed");
            $finish;
        end else begin
            cyc <= 1'b0;
            stb <= 1'b0;
            we  <= 1'b0;
        end
    endtask

    task automatic wbWrite(input logic [3:0] a, input logic [15:0] d);
        @(posedge clk);
        cyc  <= 1'b1;
        stb  <= 1'b1;
        we   <= 1'b1;
        adr  <= a;
        datW <= d;
        waitAck();
    endtask

    task automatic wbRead(input logic [3:0] a, output logic [15:0] d);
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we  <= 1'b0;
        adr <= a;
        waitAck();
        d = datR;
    endtask

    task automatic runInstr(input wiscPkg::wiscInstr_u ins, input bit writes);
        if (writes) begin
            shadow[destIndex(ins)] = expectedValue(ins);
        end
        wbWrite(wiscPkg::adrInstr, ins);
    endtask

    task automatic checkReg(input logic [2:0] idx);
        logic [15:0] got;
        wbRead(wiscPkg::adrRegBase + {1'b0, idx}, got);
        checkValue($sformatf("r%0d", idx), got, shadow[idx]);
    endtask

    task automatic checkAllRegs();
        for (int i = 0; i < 8; i++) begin
            checkReg(3'(i));
        end
    endtask

    task automatic checkStatus(input logic [15:0] exp);
        logic [15:0] got;
        wbRead(wiscPkg::adrStatus, got);
        checkValue("status", got, exp);
    endtask

    // lbi puts the high byte in place, slbi shifts it up and adds the low byte
    task automatic loadReg(input logic [2:0] idx, input logic [15:0] value);
        wiscPkg::wiscInstr_u ins;
        ins.i2Fmt = {wiscPkg::opLbi, idx, value[15:8]};
        runInstr(ins, 1'b1);
        ins.i2Fmt = {wiscPkg::opSlbi, idx, value[7:0]};
        runInstr(ins, 1'b1);
    endtask

    task automatic compareOnce(input logic [4:0] op);
        wiscPkg::wiscInstr_u ins;
        ins.rFmt = {op, 3'd1, 3'd2, 3'd3, 2'b00};
        runInstr(ins, 1'b1);
        checkReg(3'd3);
    endtask

    task automatic endTest(input string name, input int errorsBefore);
        testCount++;
        $display("test %-8s finished with %0d errors", name, errorCount - errorsBefore);
    endtask

    initial begin
        wiscPkg::wiscInstr_u ins;
        logic [31:0] r;
        int errorsBefore;
        rstN <= 1'b0;
        cyc  <= 1'b0;
        stb  <= 1'b0;
        we   <= 1'b0;
        adr  <= '0;
        datW <= '0;
        shadow = '{default: '0};
        repeat (16) @(posedge clk);
        rstN <= 1'b1;

        errorsBefore = errorCount;
        checkAllRegs();
        checkStatus(16'h0000);
        endTest("reset", errorsBefore);

        errorsBefore = errorCount;
        for (int i = 0; i < 8; i++) begin
            r = nextRandom();
            loadReg(3'(i), r[31:16]);
        end
        checkAllRegs();
        endTest("load", errorsBefore);

        errorsBefore = errorCount;
        for (int n = 0; n < 200; n++) begin
            r = nextRandom();
            ins = r[31:16];
            ins.rFmt.opcode = opPool[r[15:12]];
            runInstr(ins, 1'b1);
            checkReg(destIndex(ins));
        end
        endTest("alu", errorsBefore);

        errorsBefore = errorCount;
        for (int n = 0; n < 12; n++) begin
            r = nextRandom();
            case (n)
                0: r[15:0] = r[31:16];
                1: r = 32'h7fff_8000; // signed max against signed min
                2: r = 32'h8000_7fff;
                3: r = 32'h8000_8000;
                4: r = 32'h7fff_7fff;
                default: ;
            endcase
            loadReg(3'd1, r[31:16]);
            loadReg(3'd2, r[15:0]);
            compareOnce(wiscPkg::opSeq);
            compareOnce(wiscPkg::opSlt);
            compareOnce(wiscPkg::opSle);
        end
        endTest("compare", errorsBefore);

        errorsBefore = errorCount;
        r = nextRandom();
        ins = r[31:16];
        ins.rFmt.opcode = 5'b01100; // beqz is outside the subset
        runInstr(ins, 1'b0);
        checkAllRegs();
        checkStatus(16'h0002);
        endTest("illegal", errorsBefore);

        errorsBefore = errorCount;
        ins = '0;
        ins.rFmt.opcode = wiscPkg::opHalt;
        runInstr(ins, 1'b0);
        checkStatus(16'h0003);
        for (int n = 0; n < 10; n++) begin
            r = nextRandom();
            ins = r[31:16];
            ins.rFmt.opcode = opPool[r[15:12]];
            runInstr(ins, 1'b0); // still acked, but nothing may change
        end
        checkAllRegs();
        checkStatus(16'h0003);
        endTest("halt", errorsBefore);

        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/wiscCore_assert.sv ====
`default_nettype none

module wiscCore_assert (
    input wire logic clk,
    input wire logic rstN,
    input wire logic cyc,
    input wire logic stb,
    input wire logic ack,
    input wire logic issue,
    input wire logic halted
);

    timeunit 1ns;
    timeprecision 1ps;

    ackInCycle: assert property (@(posedge clk) disable iff (!rstN) ack |-> (cyc && stb))
        else $error("ack is high without cyc and stb");

    // every transfer gets a single-cycle ack
    ackOnePulse: assert property (@(posedge clk) disable iff (!rstN) ack |=> !ack)
        else $error("ack stayed high for two cycles");

    noIssueHalted: assert property (@(posedge clk) disable iff (!rstN) issue |-> !halted)
        else $error("an instruction issued after halt");

endmodule

bind wbSlave wiscCore_assert checks (
    .clk    (clk),
    .rstN   (rstN),
    .cyc    (cyc),
    .stb    (stb),
    .ack    (ack),
    .issue  (issue),
    .halted (halted)
);

`default_nettype wire

// ==== rtl/wiscCore.sv ====
`default_nettype none

module wiscCore (
    input  wire logic                           clk,
    input  wire logic                           rstN,
    input  wire logic                           cyc,
    input  wire logic                           stb,
    input  wire logic                           we,
    input  wire logic [wiscPkg::adrWidth-1:0]   adr,
    input  wire logic [wiscPkg::dataWidth-1:0]  datW,
    output logic      [wiscPkg::dataWidth-1:0]  datR,
    output logic                                ack
);

    wiscPkg::wiscInstr_u instr;
    wiscPkg::aluOp_e     aluOp;

    logic [wiscPkg::dataWidth-1:0]    opA;
    logic [wiscPkg::dataWidth-1:0]    opB;
    logic [wiscPkg::dataWidth-1:0]    aluResult;
    logic [wiscPkg::dataWidth-1:0]    rsData;
    logic [wiscPkg::regAddrWidth-1:0] dbgSel;
    logic issue;
    logic isHalt;
    logic illegal;

    wbSlave bus (
        .clk     (clk),
        .rstN    (rstN),
        .cyc     (cyc),
        .stb     (stb),
        .we      (we),
        .adr     (adr),
        .datW    (datW),
        .datR    (datR),
        .ack     (ack),
        .instr   (instr),
        .issue   (issue),
        .dbgSel  (dbgSel),
        .rsData  (rsData),
        .isHalt  (isHalt),
        .illegal (illegal)
    );

    decode dec (
        .clk       (clk),
        .rstN      (rstN),
        .instr     (instr),
        .issue     (issue),
        .dbgSel    (dbgSel),
        .aluResult (aluResult),
        .aluOp     (aluOp),
        .opA       (opA),
        .opB       (opB),
        .rsData    (rsData),
        .isHalt    (isHalt),
        .illegal   (illegal)
    );

    alu exec (
        .aluOp  (aluOp),
        .opA    (opA),
        .opB    (opB),
        .result (aluResult)
    );

endmodule

`default_nettype wire

// ==== rtl/wbSlave.sv ====
`default_nettype none

module wbSlave (
    input  wire logic                               clk,
    input  wire logic                               rstN,
    input  wire logic                               cyc,
    input  wire logic                               stb,
    input  wire logic                               we,
    input  wire logic [wiscPkg::adrWidth-1:0]       adr,
    input  wire logic [wiscPkg::dataWidth-1:0]      datW,
    output logic      [wiscPkg::dataWidth-1:0]      datR,
    output logic                                    ack,
    output wiscPkg::wiscInstr_u                     instr,
    output logic                                    issue,
    output logic      [wiscPkg::regAddrWidth-1:0]   dbgSel,
    input  wire logic [wiscPkg::dataWidth-1:0]      rsData,
    input  wire logic                               isHalt,
    input  wire logic                               illegal
);

    logic instrPend;
    logic halted;
    logic illegalSeen;
    logic req;
    logic instrWr;

    assign req     = cyc & stb & ~ack & ~instrPend;
    assign instrWr = req & we & (adr == wiscPkg::adrInstr);
    assign dbgSel  = adr[wiscPkg::regAddrWidth-1:0];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ack         <= 1'b0;
            issue       <= 1'b0;
            instrPend   <= 1'b0;
            halted      <= 1'b0;
            illegalSeen <= 1'b0;
        end else begin
            ack       <= instrPend | (req & ~instrWr); // instruction writes ack one edge later
            issue     <= instrWr & ~halted;
            instrPend <= instrWr;
            if (issue && isHalt) halted <= 1'b1;
            if (issue && illegal) illegalSeen <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (instrWr) instr <= datW;
        if (req && !we) begin
            if (adr >= wiscPkg::adrRegBase) begin
                datR <= rsData;
            end else if (adr == wiscPkg::adrStatus) begin
                datR <= {{(wiscPkg::dataWidth-2){1'b0}}, illegalSeen, halted};
            end else begin
                datR <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/decode.sv ====
`default_nettype none

module decode (
    input  wire logic                               clk,
    input  wire logic                               rstN,
    input  wire wiscPkg::wiscInstr_u                instr,
    input  wire logic                               issue,
    input  wire logic [wiscPkg::regAddrWidth-1:0]   dbgSel,
    input  wire logic [wiscPkg::dataWidth-1:0]      aluResult,
    output wiscPkg::aluOp_e                         aluOp,
    output logic      [wiscPkg::dataWidth-1:0]      opA,
    output logic      [wiscPkg::dataWidth-1:0]      opB,
    output logic      [wiscPkg::dataWidth-1:0]      rsData,
    output logic                                    isHalt,
    output logic                                    illegal
);

    localparam int dw = wiscPkg::dataWidth;

    logic [dw-1:0] rdData1;
    logic [dw-1:0] rdData2;
    logic [dw-1:0] imm;
    logic [wiscPkg::regAddrWidth-1:0] rdSel1;
    logic [wiscPkg::regAddrWidth-1:0] wrSel;
    logic useImm;
    logic zeroExt;
    logic immWide;
    logic rFormat;
    logic regWrite;

    assign rdSel1 = issue ? instr.rFmt.rs : dbgSel; // host readback borrows port 1 when idle

    always_comb begin
        if (rFormat) begin
            wrSel = instr.rFmt.rd;
        end else if (immWide) begin
            wrSel = instr.i2Fmt.rs; // lbi and slbi write back to rs
        end else begin
            wrSel = instr.i1Fmt.rd;
        end
    end

    always_comb begin
        if (immWide) begin
            imm = zeroExt ? {{(dw-8){1'b0}}, instr.i2Fmt.imm8}
                          : {{(dw-8){instr.i2Fmt.imm8[7]}}, instr.i2Fmt.imm8};
        end else begin
            imm = zeroExt ? {{(dw-5){1'b0}}, instr.i1Fmt.imm5}
                          : {{(dw-5){instr.i1Fmt.imm5[4]}}, instr.i1Fmt.imm5};
        end
    end

    assign opA    = (aluOp == wiscPkg::aluOrImm) ? (rdData1 << 8) : rdData1;
    assign opB    = useImm ? imm : rdData2;
    assign rsData = rdData1;

    regFile regs (
        .clk     (clk),
        .rstN    (rstN),
        .rdSel1  (rdSel1),
        .rdSel2  (instr.rFmt.rt),
        .wrSel   (wrSel),
        .wrEn    (issue & regWrite),
        .wrData  (aluResult),
        .rdData1 (rdData1),
        .rdData2 (rdData2)
    );

    controlUnit ctrl (
        .instr    (instr),
        .aluOp    (aluOp),
        .useImm   (useImm),
        .zeroExt  (zeroExt),
        .immWide  (immWide),
        .rFormat  (rFormat),
        .regWrite (regWrite),
        .isHalt   (isHalt),
        .illegal  (illegal)
    );

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`default_nettype none

module alu (
    input  wire wiscPkg::aluOp_e                aluOp,
    input  wire logic [wiscPkg::dataWidth-1:0]  opA,
    input  wire logic [wiscPkg::dataWidth-1:0]  opB,
    output logic      [wiscPkg::dataWidth-1:0]  result
);

    localparam int dw = wiscPkg::dataWidth;

    logic [3:0]      amt;
    logic [2*dw-1:0] rolWide;
    logic [2*dw-1:0] rorWide;
    logic            isEq;
    logic            isLt;

    assign amt = opB[3:0];

    // rotating a doubled word keeps the wrapped bits in view
    assign rolWide = {opA, opA} << amt;
    assign rorWide = {opA, opA} >> amt;

    assign isEq = (opA == opB);
    assign isLt = ($signed(opA) < $signed(opB));

    always_comb begin
        case (aluOp)
            wiscPkg::aluAdd:   result = opA + opB;
            wiscPkg::aluSub:   result = opB - opA; // rd = rt - rs
            wiscPkg::aluXor:   result = opA ^ opB;
            wiscPkg::aluAndn:  result = opA & ~opB;
            wiscPkg::aluRol:   result = rolWide[2*dw-1:dw];
            wiscPkg::aluSll:   result = opA << amt;
            wiscPkg::aluRor:   result = rorWide[dw-1:0];
            wiscPkg::aluSrl:   result = opA >> amt;
            wiscPkg::aluSeq:   result = {{(dw-1){1'b0}}, isEq};
            wiscPkg::aluSlt:   result = {{(dw-1){1'b0}}, isLt};
            wiscPkg::aluSle:   result = {{(dw-1){1'b0}}, isLt | isEq};
            wiscPkg::aluOrImm: result = opA | opB;
            default:           result = opB; // passB for lbi
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/controlUnit.sv ====
`default_nettype none

module controlUnit (
    input  wire wiscPkg::wiscInstr_u instr,
    output wiscPkg::aluOp_e          aluOp,
    output logic                     useImm,
    output logic                     zeroExt,
    output logic                     immWide,
    output logic                     rFormat,
    output logic                     regWrite,
    output logic                     isHalt,
    output logic                     illegal
);

    always_comb begin
        aluOp    = wiscPkg::aluPassB;
        useImm   = 1'b0;
        zeroExt  = 1'b0;
        immWide  = 1'b0;
        rFormat  = 1'b0;
        regWrite = 1'b0;
        isHalt   = 1'b0;
        illegal  = 1'b0;

        case (instr.rFmt.opcode)
            wiscPkg::opHalt: isHalt = 1'b1;
            wiscPkg::opNop: ; // nothing to do
            wiscPkg::opAddi, wiscPkg::opSubi: begin
                aluOp    = (instr.rFmt.opcode == wiscPkg::opAddi) ? wiscPkg::aluAdd
                                                                   : wiscPkg::aluSub;
                useImm   = 1'b1;
                regWrite = 1'b1;
            end
            wiscPkg::opXori, wiscPkg::opAndni: begin
                aluOp    = (instr.rFmt.opcode == wiscPkg::opXori) ? wiscPkg::aluXor
                                                                   : wiscPkg::aluAndn;
                useImm   = 1'b1;
                zeroExt  = 1'b1; // logic immediates are unsigned
                regWrite = 1'b1;
            end
            wiscPkg::opRoli, wiscPkg::opSlli, wiscPkg::opRori, wiscPkg::opSrli: begin
                case (instr.rFmt.opcode)
                    wiscPkg::opRoli: aluOp = wiscPkg::aluRol;
                    wiscPkg::opSlli: aluOp = wiscPkg::aluSll;
                    wiscPkg::opRori: aluOp = wiscPkg::aluRor;
                    default:         aluOp = wiscPkg::aluSrl;
                endcase
                useImm   = 1'b1;
                zeroExt  = 1'b1;
                regWrite = 1'b1;
            end
            wiscPkg::opLbi: begin
                useImm   = 1'b1;
                immWide  = 1'b1;
                regWrite = 1'b1;
            end
            wiscPkg::opSlbi: begin
                aluOp    = wiscPkg::aluOrImm;
                useImm   = 1'b1;
                immWide  = 1'b1;
                zeroExt  = 1'b1;
                regWrite = 1'b1;
            end
            wiscPkg::opAluR: begin
                case (instr.rFmt.func)
                    wiscPkg::funcAdd: aluOp = wiscPkg::aluAdd;
                    wiscPkg::funcSub: aluOp = wiscPkg::aluSub;
                    wiscPkg::funcXor: aluOp = wiscPkg::aluXor;
                    default:          aluOp = wiscPkg::aluAndn;
                endcase
                rFormat  = 1'b1;
                regWrite = 1'b1;
            end
            wiscPkg::opSeq, wiscPkg::opSlt, wiscPkg::opSle: begin
                case (instr.rFmt.opcode)
                    wiscPkg::opSeq: aluOp = wiscPkg::aluSeq;
                    wiscPkg::opSlt: aluOp = wiscPkg::aluSlt;
                    default:        aluOp = wiscPkg::aluSle;
                endcase
                rFormat  = 1'b1;
                regWrite = 1'b1;
            end
            default: illegal = 1'b1; // branches, jumps, memory ops and the rest
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
`default_nettype none

module regFile (
    input  wire logic                               clk,
    input  wire logic                               rstN,
    input  wire logic [wiscPkg::regAddrWidth-1:0]   rdSel1,
    input  wire logic [wiscPkg::regAddrWidth-1:0]   rdSel2,
    input  wire logic [wiscPkg::regAddrWidth-1:0]   wrSel,
    input  wire logic                               wrEn,
    input  wire logic [wiscPkg::dataWidth-1:0]      wrData,
    output logic      [wiscPkg::dataWidth-1:0]      rdData1,
    output logic      [wiscPkg::dataWidth-1:0]      rdData2
);

    localparam int numRegs = 2 ** wiscPkg::regAddrWidth;

    logic [wiscPkg::dataWidth-1:0] regs [numRegs];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrSel] <= wrData;
        end
    end

    // reads see the value from before a write on the same edge
    assign rdData1 = regs[rdSel1];
    assign rdData2 = regs[rdSel2];

endmodule

`default_nettype wire

// ==== rtl/wiscPkg.sv ====
`default_nettype none

package wiscPkg;

    localparam int dataWidth    = 16;
    localparam int regAddrWidth = 3;
    localparam int adrWidth     = 4;

    // opcodes live in the top five bits of every instruction
    localparam logic [4:0] opHalt  = 5'b00000;
    localparam logic [4:0] opNop   = 5'b00001;
    localparam logic [4:0] opAddi  = 5'b01000;
    localparam logic [4:0] opSubi  = 5'b01001;
    localparam logic [4:0] opXori  = 5'b01010;
    localparam logic [4:0] opAndni = 5'b01011;
    localparam logic [4:0] opRoli  = 5'b10100;
    localparam logic [4:0] opSlli  = 5'b10101;
    localparam logic [4:0] opRori  = 5'b10110;
    localparam logic [4:0] opSrli  = 5'b10111;
    localparam logic [4:0] opLbi   = 5'b11000;
    localparam logic [4:0] opSlbi  = 5'b10010;
    localparam logic [4:0] opAluR  = 5'b11011;
    localparam logic [4:0] opSeq   = 5'b11100;
    localparam logic [4:0] opSlt   = 5'b11101;
    localparam logic [4:0] opSle   = 5'b11110;

    localparam logic [1:0] funcAdd  = 2'b00;
    localparam logic [1:0] funcSub  = 2'b01;
    localparam logic [1:0] funcXor  = 2'b10;
    localparam logic [1:0] funcAndn = 2'b11;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluXor, aluAndn,
        aluRol, aluSll, aluRor, aluSrl,
        aluSeq, aluSlt, aluSle, aluPassB,
        aluOrImm // slbi merges the shifted rs with imm8
    } aluOp_e;

    // the same word seen as R, I1 or I2 format
    typedef union packed {
        struct packed {
            logic [4:0] opcode;
            logic [2:0] rs;
            logic [2:0] rt;
            logic [2:0] rd;
            logic [1:0] func;
        } rFmt;
        struct packed {
            logic [4:0] opcode;
            logic [2:0] rs;
            logic [2:0] rd;
            logic [4:0] imm5;
        } i1Fmt;
        struct packed {
            logic [4:0] opcode;
            logic [2:0] rs;
            logic [7:0] imm8;
        } i2Fmt;
    } wiscInstr_u;

    localparam logic [adrWidth-1:0] adrInstr   = 4'h0;
    localparam logic [adrWidth-1:0] adrStatus  = 4'h1;
    localparam logic [adrWidth-1:0] adrRegBase = 4'h8; // registers sit at 8 to 15

endpackage

`default_nettype wire
